// ==== Makefile ====
TOP = uart_manage_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f uart_manage.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== hdl/byte_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module byte_fifo
    import uart_pkg::*;
    (input  logic              i_push,
     input  logic [BYTE_W-1:0] i_push_data,
     output logic              o_full,
     input  logic              i_pop,
     output logic [BYTE_W-1:0] o_pop_data,
     output logic              o_empty,
     input  logic              clk,
     input  logic              i_rst);

    logic [BYTE_W-1:0]      mem [FIFO_DEPTH];
    logic [FIFO_ADDR_W-1:0] wr_ptr;
    logic [FIFO_ADDR_W-1:0] rd_ptr;
    logic [FIFO_ADDR_W:0]   count;
    logic                   do_push;
    logic                   do_pop;

    assign o_full  = (count == (FIFO_ADDR_W + 1)'(FIFO_DEPTH));
    assign o_empty = (count == '0);

    // blocked requests are dropped here
    assign do_push = i_push & ~o_full;
    assign do_pop  = i_pop & ~o_empty;

    // show-ahead, head entry always visible
    assign o_pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_push_data;
        end
    end

    // pointers wrap naturally
    always_ff @(posedge clk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/uart_manage.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_manage
    import uart_pkg::*;
    (input  logic              i_order,
     output logic              o_accepted,
     output logic              o_done,
     input  logic [SIZE_W-1:0] i_size,
     input  logic              i_write_flag,
     input  logic [DATA_W-1:0] i_write_data,
     output logic [DATA_W-1:0] o_read_data,

     input  logic              i_rxd,
     output logic              o_txd,
     input  logic              clk,
     input  logic              i_rst);

    // receive side
    logic              rx_valid;
    logic [BYTE_W-1:0] rx_byte;
    logic              rx_pop;
    logic [BYTE_W-1:0] rx_pop_data;
    logic              rx_empty;

    // transmit side
    logic              tx_push;
    logic [BYTE_W-1:0] tx_push_data;
    logic              tx_full;
    logic              tx_take;
    logic [BYTE_W-1:0] tx_pop_data;
    logic              tx_empty;
    logic              tx_valid;

    uart_rx urx (
        .i_rxd   (i_rxd),
        .clk     (clk),
        .i_rst   (i_rst),
        .o_valid (rx_valid),
        .o_data  (rx_byte));

    // overflow is dropped silently, full flag not needed
    byte_fifo rx_fifo (
        .i_push      (rx_valid),
        .i_push_data (rx_byte),
        .o_full      (),
        .i_pop       (rx_pop),
        .o_pop_data  (rx_pop_data),
        .o_empty     (rx_empty),
        .clk         (clk),
        .i_rst       (i_rst));

    uart_word_port uwp (
        .i_order      (i_order),
        .o_accepted   (o_accepted),
        .o_done       (o_done),
        .i_size       (i_size),
        .i_write_flag (i_write_flag),
        .i_write_data (i_write_data),
        .o_read_data  (o_read_data),
        .o_tx_push    (tx_push),
        .o_tx_data    (tx_push_data),
        .i_tx_full    (tx_full),
        .o_rx_pop     (rx_pop),
        .i_rx_data    (rx_pop_data),
        .i_rx_empty   (rx_empty),
        .clk          (clk),
        .i_rst        (i_rst));

    byte_fifo tx_fifo (
        .i_push      (tx_push),
        .i_push_data (tx_push_data),
        .o_full      (tx_full),
        .i_pop       (tx_take),
        .o_pop_data  (tx_pop_data),
        .o_empty     (tx_empty),
        .clk         (clk),
        .i_rst       (i_rst));

    assign tx_valid = ~tx_empty;

    uart_tx utx (
        .i_valid (tx_valid),
        .i_data  (tx_pop_data),
        .o_take  (tx_take),
        .o_txd   (o_txd),
        .clk     (clk),
        .i_rst   (i_rst));

endmodule

`default_nettype wire

// ==== hdl/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

    // host word and serial byte
    localparam int DATA_W = 32;
    localparam int BYTE_W = 8;

    // size codes, code 3 behaves as a word
    localparam int SIZE_W = 2;
    localparam logic [SIZE_W-1:0] SIZE_BYTE = 2'd0;
    localparam logic [SIZE_W-1:0] SIZE_HALF = 2'd1;
    localparam logic [SIZE_W-1:0] SIZE_WORD = 2'd2;

    // bit timing, any value of 4 or more works
    localparam int CLKS_PER_BIT = 8;
    localparam int CLK_CNT_W = $clog2(CLKS_PER_BIT);

    // start + data + stop
    localparam int FRAME_W = BYTE_W + 2;

    // byte fifo geometry, depth must be a power of two
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_ADDR_W = 4;

endpackage

`default_nettype wire

// ==== hdl/uart_rx.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_rx
    import uart_pkg::*;
    (input  logic              i_rxd,
     input  logic              clk,
     input  logic              i_rst,
     output logic              o_valid,
     output logic [BYTE_W-1:0] o_data);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t            state;
    logic                 rxd_meta;
    logic                 rxd_sync;
    logic                 rxd_prev;
    logic [CLK_CNT_W-1:0] clk_cnt;
    logic [2:0]           bit_cnt;
    logic [BYTE_W-1:0]    shift;
    logic                 mid_start;
    logic                 bit_end;

    // line idles high, so the synchronizer resets to 1
    always_ff @(posedge clk) begin
        if (i_rst) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= i_rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    assign mid_start = (clk_cnt == CLK_CNT_W'(CLKS_PER_BIT / 2 - 1));
    assign bit_end   = (clk_cnt == CLK_CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state   <= RX_IDLE;
            clk_cnt <= '0;
            bit_cnt <= '0;
            o_valid <= 1'b0;
        end else begin
            o_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    bit_cnt <= '0;
                    if (rxd_prev && !rxd_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (mid_start) begin
                        clk_cnt <= '0;
                        // still high at mid-bit means a glitch
                        state   <= rxd_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        clk_cnt <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        // bad stop bit drops the byte
                        o_valid <= rxd_sync;
                        state   <= RX_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_end) begin
            shift <= {rxd_sync, shift[BYTE_W-1:1]};
        end
    end

    assign o_data = shift;

endmodule

`default_nettype wire

// ==== hdl/uart_tx.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_tx
    import uart_pkg::*;
    (input  logic              i_valid,
     input  logic [BYTE_W-1:0] i_data,
     output logic              o_take,
     output logic              o_txd,
     input  logic              clk,
     input  logic              i_rst);

    logic                 busy;
    logic [CLK_CNT_W-1:0] clk_cnt;
    logic [3:0]           bit_cnt;
    logic [FRAME_W-1:0]   frame;
    logic                 bit_end;

    // a byte is taken only between frames
    assign o_take = i_valid & ~busy;

    // frame fills with ones as it shifts, so the line rests high
    assign o_txd = frame[0];

    assign bit_end = (clk_cnt == CLK_CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (i_rst) begin
            busy    <= 1'b0;
            clk_cnt <= '0;
            bit_cnt <= '0;
            frame   <= '1;
        end else if (o_take) begin
            busy    <= 1'b1;
            clk_cnt <= '0;
            bit_cnt <= '0;
            // stop, data lsb first, start
            frame   <= {1'b1, i_data, 1'b0};
        end else if (busy) begin
            if (bit_end) begin
                clk_cnt <= '0;
                frame   <= {1'b1, frame[FRAME_W-1:1]};
                // idle only once the stop bit has run its full time
                if (bit_cnt == 4'(FRAME_W - 1)) begin
                    busy <= 1'b0;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/uart_word_port.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_word_port
    import uart_pkg::*;
    (input  logic              i_order,
     output logic              o_accepted,
     output logic              o_done,
     input  logic [SIZE_W-1:0] i_size,
     input  logic              i_write_flag,
     input  logic [DATA_W-1:0] i_write_data,
     output logic [DATA_W-1:0] o_read_data,

     output logic              o_tx_push,
     output logic [BYTE_W-1:0] o_tx_data,
     input  logic              i_tx_full,

     output logic              o_rx_pop,
     input  logic [BYTE_W-1:0] i_rx_data,
     input  logic              i_rx_empty,

     input  logic              clk,
     input  logic              i_rst);

    logic              busy;
    logic [2:0]        remaining;
    logic              r_write;
    logic [SIZE_W-1:0] r_size;
    logic [DATA_W-1:0] wr_shift;
    logic [DATA_W-1:0] rd_shift;
    logic [DATA_W-1:0] read_data;

    logic [2:0]        order_bytes;
    logic [DATA_W-1:0] write_aligned;
    logic              moving;
    logic [DATA_W-1:0] rd_next;
    logic [DATA_W-1:0] rd_extended;

    assign o_accepted = i_order & ~busy;

    // busy stays up through the done cycle
    assign moving    = busy & (remaining != '0);
    assign o_done    = busy & (remaining == '0);
    assign o_tx_push = moving & r_write & ~i_tx_full;
    assign o_rx_pop  = moving & ~r_write & ~i_rx_empty;

    // top byte goes out first
    assign o_tx_data = wr_shift[DATA_W-1 -: BYTE_W];

    assign o_read_data = read_data;

    // byte count and left alignment from the size code
    always_comb begin
        case (i_size)
            SIZE_BYTE: begin
                order_bytes   = 3'd1;
                write_aligned = {i_write_data[BYTE_W-1:0], {(DATA_W - BYTE_W){1'b0}}};
            end
            SIZE_HALF: begin
                order_bytes   = 3'd2;
                write_aligned = {i_write_data[2*BYTE_W-1:0], {(DATA_W - 2*BYTE_W){1'b0}}};
            end
            default: begin
                order_bytes   = 3'd4;
                write_aligned = i_write_data;
            end
        endcase
    end

    // new byte enters at the bottom
    assign rd_next = {rd_shift[DATA_W-BYTE_W-1:0], i_rx_data};

    always_comb begin
        case (r_size)
            SIZE_BYTE: begin
                rd_extended = {{(DATA_W - BYTE_W){rd_next[BYTE_W-1]}},
                               rd_next[BYTE_W-1:0]};
            end
            SIZE_HALF: begin
                rd_extended = {{(DATA_W - 2*BYTE_W){rd_next[2*BYTE_W-1]}},
                               rd_next[2*BYTE_W-1:0]};
            end
            default: begin
                rd_extended = rd_next;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            busy      <= 1'b0;
            remaining <= '0;
        end else if (o_accepted) begin
            busy      <= 1'b1;
            remaining <= order_bytes;
        end else if (o_done) begin
            busy <= 1'b0;
        end else if (o_tx_push || o_rx_pop) begin
            remaining <= remaining - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (o_accepted) begin
            r_write  <= i_write_flag;
            r_size   <= i_size;
            wr_shift <= write_aligned;
        end else if (o_tx_push) begin
            wr_shift <= {wr_shift[DATA_W-BYTE_W-1:0], {BYTE_W{1'b0}}};
        end
    end

    // result lands with the last byte, ready in the done cycle
    always_ff @(posedge clk) begin
        if (o_rx_pop) begin
            rd_shift <= rd_next;
            if (remaining == 3'd1) begin
                read_data <= rd_extended;
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/uart_manage_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_manage_tb
    import uart_pkg::*;
    ();

    localparam int          CLK_PERIOD = 8;
    localparam logic [31:0] LFSR_SEED  = 32'hf786_cde3;
    localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;
    localparam logic        OP_WR      = 1'b1;
    localparam logic        OP_RD      = 1'b0;

    logic              clk;
    logic              i_rst;
    logic              i_order;
    logic [SIZE_W-1:0] i_size;
    logic              i_write_flag;
    logic [DATA_W-1:0] i_write_data;
    logic              o_accepted;
    logic              o_done;
    logic [DATA_W-1:0] o_read_data;
    logic              serial_line;

    // order table
    logic              tbl_write  [$];
    logic [SIZE_W-1:0] tbl_size   [$];
    logic [DATA_W-1:0] tbl_data   [$];
    logic              tbl_random [$];
    logic              tbl_poke   [$];

    // bytes in flight, oldest first
    logic [BYTE_W-1:0] model_bytes [$];

    logic [31:0] lfsr_state;
    int          n_orders = 0;
    int          pass_count;
    int          fail_count;
    int          entry_errors;

    // loopback, txd feeds rxd
    uart_manage DUT (
        .i_order      (i_order),
        .o_accepted   (o_accepted),
        .o_done       (o_done),
        .i_size       (i_size),
        .i_write_flag (i_write_flag),
        .i_write_data (i_write_data),
        .o_read_data  (o_read_data),
        .i_rxd        (serial_line),
        .o_txd        (serial_line),
        .clk          (clk),
        .i_rst        (i_rst));

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // one lfsr step per bit
    function automatic logic [DATA_W-1:0] random_word();
        logic [DATA_W-1:0] w;
        w = '0;
        for (int i = 0; i < DATA_W; i++) begin
            w = {w[DATA_W-2:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return w;
    endfunction

    function automatic int size_bytes(input logic [SIZE_W-1:0] size);
        if (size == SIZE_BYTE) begin
            return 1;
        end else if (size == SIZE_HALF) begin
            return 2;
        end
        return 4;
    endfunction

    task automatic model_write(input logic [SIZE_W-1:0] size, input logic [DATA_W-1:0] data);
        int n;
        n = size_bytes(size);
        for (int i = n - 1; i >= 0; i--) begin
            model_bytes.push_back(data[BYTE_W*i +: BYTE_W]);
        end
    endtask

    // msb first, sign bit is the top bit of the last size
    function automatic logic [DATA_W-1:0] model_read(input logic [SIZE_W-1:0] size);
        int                n;
        logic [DATA_W-1:0] v;
        n = size_bytes(size);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[DATA_W-BYTE_W-1:0], model_bytes.pop_front()};
        end
        if (n < 4 && v[BYTE_W*n-1]) begin
            v = v | ({DATA_W{1'b1}} << (BYTE_W * n));
        end
        return v;
    endfunction

    task automatic add_order(input logic wr, input logic [SIZE_W-1:0] size,
                             input logic [DATA_W-1:0] data, input logic rnd,
                             input logic poke);
        tbl_write.push_back(wr);
        tbl_size.push_back(size);
        tbl_data.push_back(data);
        tbl_random.push_back(rnd);
        tbl_poke.push_back(poke);
    endtask

    task automatic build_table();
        // word round trips
        add_order(OP_WR, SIZE_WORD, 32'h1234_5678, 1'b0, 1'b0);
        add_order(OP_RD, SIZE_WORD, 32'h0,         1'b0, 1'b1);
        add_order(OP_WR, SIZE_WORD, 32'h0,         1'b1, 1'b0);
        add_order(OP_RD, SIZE_WORD, 32'h0,         1'b0, 1'b0);
        add_order(OP_WR, SIZE_WORD, 32'h0,         1'b1, 1'b0);
        add_order(OP_RD, SIZE_WORD, 32'h0,         1'b0, 1'b0);
        add_order(OP_WR, SIZE_WORD, 32'h8765_4321, 1'b0, 1'b0);
        add_order(OP_RD, SIZE_WORD, 32'h0,         1'b0, 1'b0);
        // narrow sizes, upper bits of the data must be ignored
        add_order(OP_WR, SIZE_BYTE, 32'h1234_5685, 1'b0, 1'b1);
        add_order(OP_RD, SIZE_BYTE, 32'h0,         1'b0, 1'b0);
        add_order(OP_WR, SIZE_BYTE, 32'h0000_007a, 1'b0, 1'b0);
        add_order(OP_RD, SIZE_BYTE, 32'h0,         1'b0, 1'b0);
        add_order(OP_WR, SIZE_HALF, 32'habcd_9234, 1'b0, 1'b0);
        add_order(OP_RD, SIZE_HALF, 32'h0,         1'b0, 1'b0);
        add_order(OP_WR, SIZE_HALF, 32'h0000_4321, 1'b0, 1'b1);
        add_order(OP_RD, SIZE_HALF, 32'h0,         1'b0, 1'b0);
        add_order(OP_WR, SIZE_BYTE, 32'h0,         1'b1, 1'b0);
        add_order(OP_RD, SIZE_BYTE, 32'h0,         1'b0, 1'b0);
        add_order(OP_WR, SIZE_HALF, 32'h0,         1'b1, 1'b0);
        add_order(OP_RD, SIZE_HALF, 32'h0,         1'b0, 1'b0);
        // mixed sizes
        add_order(OP_WR, SIZE_WORD, 32'hc0de_7f01, 1'b0, 1'b0);
        add_order(OP_RD, SIZE_BYTE, 32'h0,         1'b0, 1'b0);
        add_order(OP_RD, SIZE_BYTE, 32'h0,         1'b0, 1'b0);
        add_order(OP_RD, SIZE_BYTE, 32'h0,         1'b0, 1'b0);
        add_order(OP_RD, SIZE_BYTE, 32'h0,         1'b0, 1'b1);
        add_order(OP_WR, SIZE_HALF, 32'h0000_a1b2, 1'b0, 1'b0);
        add_order(OP_WR, SIZE_HALF, 32'hffff_c3d4, 1'b0, 1'b0);
        add_order(OP_RD, SIZE_WORD, 32'h0,         1'b0, 1'b0);
        // code 3 acts as a word
        add_order(OP_WR, 2'd3,      32'h0,         1'b1, 1'b0);
        add_order(OP_RD, SIZE_WORD, 32'h0,         1'b0, 1'b0);
        // queued writes, then reads that stall on the rx fifo
        add_order(OP_WR, SIZE_WORD, 32'h0,         1'b1, 1'b0);
        add_order(OP_WR, SIZE_WORD, 32'h0,         1'b1, 1'b0);
        add_order(OP_WR, SIZE_WORD, 32'h0,         1'b1, 1'b0);
        add_order(OP_RD, SIZE_WORD, 32'h0,         1'b0, 1'b0);
        add_order(OP_RD, SIZE_WORD, 32'h0,         1'b0, 1'b0);
        add_order(OP_RD, SIZE_WORD, 32'h0,         1'b0, 1'b1);
    endtask

    task automatic tally(input string what);
        if (entry_errors == 0) begin
            pass_count++;
            $display("%s: ok", what);
        end else begin
            fail_count++;
            $display("%s: %0d error(s)", what, entry_errors);
        end
    endtask

    task automatic check_reset();
        entry_errors = 0;
        @(negedge clk);
        assert (o_txd_idle()) else begin
            $display("[FAIL] %t o_txd expected 1 got %b", $realtime, serial_line);
            entry_errors++;
        end
        assert (o_done === 1'b0) else begin
            $display("[FAIL] %t o_done expected 0 got %b", $realtime, o_done);
            entry_errors++;
        end
        assert (o_accepted === i_order) else begin
            $display("[FAIL] %t o_accepted expected %b got %b", $realtime, i_order, o_accepted);
            entry_errors++;
        end
        tally("reset state");
    endtask

    function automatic logic o_txd_idle();
        return serial_line === 1'b1;
    endfunction

    task automatic run_order(input int idx);
        logic [DATA_W-1:0] data;
        logic [DATA_W-1:0] expected;
        int                n;
        int                cycles;
        entry_errors = 0;
        n = size_bytes(tbl_size[idx]);
        data = tbl_random[idx] ? random_word() : tbl_data[idx];
        expected = '0;
        @(posedge clk);
        #1;
        i_order      = 1'b1;
        i_size       = tbl_size[idx];
        i_write_flag = tbl_write[idx];
        i_write_data = data;
        @(negedge clk);
        assert (o_accepted === 1'b1) else begin
            $display("[FAIL] %t o_accepted expected 1 got %b", $realtime, o_accepted);
            entry_errors++;
        end
        if (tbl_write[idx]) begin
            model_write(tbl_size[idx], data);
        end else begin
            expected = model_read(tbl_size[idx]);
        end
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            // a second order while busy, with a different payload
            if (tbl_poke[idx] && cycles == 0) begin
                i_write_flag = ~tbl_write[idx];
                i_write_data = ~data;
            end else begin
                i_order = 1'b0;
            end
            @(negedge clk);
            cycles++;
            if (i_order) begin
                assert (o_accepted === 1'b0) else begin
                    $display("[FAIL] %t o_accepted expected 0 got %b", $realtime, o_accepted);
                    entry_errors++;
                end
            end
        end while (o_done !== 1'b1);
        if (tbl_write[idx]) begin
            assert (cycles == n + 1) else begin
                $display("[FAIL] %t o_done latency expected %0d got %0d",
                         $realtime, n + 1, cycles);
                entry_errors++;
            end
        end else begin
            assert (o_read_data === expected) else begin
                $display("[FAIL] %t o_read_data expected %h got %h",
                         $realtime, expected, o_read_data);
                entry_errors++;
            end
        end
        tally($sformatf("order %0d %s %0d byte(s) %h", idx,
                        tbl_write[idx] ? "write" : "read", n,
                        tbl_write[idx] ? data : o_read_data));
    endtask

    // bound scales with the table length
    initial begin
        int bound_ns;
        wait (n_orders > 0);
        bound_ns = n_orders * 4 * 10 * CLKS_PER_BIT * CLK_PERIOD * 3;
        #(bound_ns);
        $display("timeout: orders still running after %0d ns", bound_ns);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        $timeformat(-9, 1, " ns", 0);
        i_rst        = 1'b1;
        i_order      = 1'b0;
        i_size       = SIZE_WORD;
        i_write_flag = 1'b0;
        i_write_data = '0;
        lfsr_state   = LFSR_SEED;
        pass_count   = 0;
        fail_count   = 0;
        build_table();
        n_orders = tbl_write.size();
        repeat (2) @(posedge clk);
        #1;
        i_rst = 1'b0;
        check_reset();
        for (int i = 0; i < n_orders; i++) begin
            run_order(i);
        end
        $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== uart_manage.f ====
hdl/uart_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/byte_fifo.sv
hdl/uart_word_port.sv
hdl/uart_manage.sv
test/uart_manage_tb.sv
